/* Makefile */
TOOL       = verilator
TOP        = tb_bitrev_reorder
FILELIST   = list.f
BUILD_DIR  = obj_dir
FLAGS      = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing -Wall
RUN_FLAGS  = +verilator+error+limit+1000
LOG        = sim.log
FAIL_MSG   = SIMULATION FAILED

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# a crashed run counts as a failed one
run: build
	./$(BUILD_DIR)/V$(TOP) $(RUN_FLAGS) > $(LOG) 2>&1 || echo "$(FAIL_MSG)" >> $(LOG)
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "run failed, see $(LOG)"; exit 1; fi

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* bitrev_reorder_top.sv */
`timescale 1ns/10ps
`default_nettype none

module bitrev_reorder_top import br_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    in_valid,
    input  sample_t in_re [lanes],
    input  sample_t in_im [lanes],
    output logic    out_valid,
    output sample_t out_re [lanes],
    output sample_t out_im [lanes],
    output block_t  out_block,
    output logic    out_last
);

    // write side
    logic   wr_en;
    bank_t  wr_bank;
    addr_t  wr_addr [lanes];

    // hand-over between the two sides
    logic   frame_ready;
    bank_t  full_bank;

    // read side
    logic   rd_en;
    bank_t  rd_bank;
    block_t rd_block;

    frame_writer i_frame_writer (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .wr_en       (wr_en),
        .wr_bank     (wr_bank),
        .wr_addr     (wr_addr),
        .frame_ready (frame_ready),
        .full_bank   (full_bank)
    );

    // input samples go straight to the banks
    reorder_ram i_reorder_ram (
        .clk      (clk),
        .wr_en    (wr_en),
        .wr_bank  (wr_bank),
        .wr_addr  (wr_addr),
        .wr_re    (in_re),
        .wr_im    (in_im),
        .rd_en    (rd_en),
        .rd_bank  (rd_bank),
        .rd_block (rd_block),
        .rd_re    (out_re),
        .rd_im    (out_im)
    );

    read_sequencer i_read_sequencer (
        .clk         (clk),
        .rst_n       (rst_n),
        .frame_ready (frame_ready),
        .full_bank   (full_bank),
        .rd_en       (rd_en),
        .rd_bank     (rd_bank),
        .rd_block    (rd_block),
        .out_valid   (out_valid),
        .out_block   (out_block),
        .out_last    (out_last)
    );

endmodule

`default_nettype wire

/* br_pkg.sv */
`default_nettype none

package br_pkg;

    // sample and frame geometry
    localparam int sample_w   = 13;
    localparam int lanes      = 16;
    localparam int lane_bits  = 4;
    localparam int frame_len  = 512;
    localparam int addr_bits  = 9;
    localparam int blocks     = 32;
    localparam int block_bits = 5;

    typedef logic signed [sample_w-1:0] sample_t;  // one real or imaginary part
    typedef logic [addr_bits-1:0]       addr_t;    // point index in a frame
    typedef logic [block_bits-1:0]      block_t;   // beat index in a frame
    typedef logic                       bank_t;

    typedef enum logic {
        seq_idle,
        seq_read
    } seq_state_t;

    // mirror the index bits, msb <-> lsb
    function automatic addr_t bitrev(input addr_t idx);
        addr_t rev;
        for (int b = 0; b < addr_bits; b++) begin
            rev[b] = idx[addr_bits-1-b];
        end
        return rev;
    endfunction

endpackage

`default_nettype wire

/* frame_writer.sv */
`timescale 1ns/10ps
`default_nettype none

module frame_writer import br_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  in_valid,
    output logic  wr_en,
    output bank_t wr_bank,
    output addr_t wr_addr [lanes],
    output logic  frame_ready,
    output bank_t full_bank
);

    block_t wr_block;  // beat within the frame being written
    logic   last_beat;

    assign wr_en     = in_valid;  // every valid beat is written
    assign last_beat = in_valid && (wr_block == block_t'(blocks - 1));

    // scatter each lane to its bit-reversed point index
    always_comb begin
        for (int i = 0; i < lanes; i++) begin
            wr_addr[i] = bitrev({wr_block, lane_bits'(i)});
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_block <= '0;
            wr_bank  <= '0;
        end else if (in_valid) begin
            if (last_beat) begin
                wr_block <= '0;
                wr_bank  <= ~wr_bank;  // next frame goes to the other bank
            end else begin
                wr_block <= wr_block + 1'b1;
            end
        end
    end

    // one cycle pulse naming the bank just filled
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            frame_ready <= 1'b0;
            full_bank   <= '0;
        end else begin
            frame_ready <= last_beat;
            if (last_beat) begin
                full_bank <= wr_bank;
            end
        end
    end

endmodule

`default_nettype wire

/* list.f */
br_pkg.sv
frame_writer.sv
reorder_ram.sv
read_sequencer.sv
bitrev_reorder_top.sv
reorder_props.sv
reorder_checker.sv
tb_bitrev_reorder.sv

/* read_sequencer.sv */
`timescale 1ns/10ps
`default_nettype none

module read_sequencer import br_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   frame_ready,
    input  bank_t  full_bank,
    output logic   rd_en,
    output bank_t  rd_bank,
    output block_t rd_block,
    output logic   out_valid,
    output block_t out_block,
    output logic   out_last
);

    seq_state_t state;

    // read requests are registered; block 0 is issued at the edge that
    // sees frame_ready, block 31 at the edge that drops back to idle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= seq_idle;
            rd_en    <= 1'b0;
            rd_bank  <= '0;
            rd_block <= '0;
        end else begin
            case (state)
                seq_idle: begin
                    if (frame_ready) begin
                        state    <= seq_read;
                        rd_en    <= 1'b1;
                        rd_bank  <= full_bank;  // latch the finished bank
                        rd_block <= '0;
                    end else begin
                        rd_en    <= 1'b0;
                    end
                end
                seq_read: begin
                    rd_en    <= 1'b1;
                    rd_block <= rd_block + 1'b1;
                    if (rd_block == block_t'(blocks - 2)) begin
                        state <= seq_idle;  // last block goes out next
                    end
                end
                default: begin
                    state <= seq_idle;
                    rd_en <= 1'b0;
                end
            endcase
        end
    end

    // one cycle behind the request, in step with the ram output regs
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            out_block <= '0;
            out_last  <= 1'b0;
        end else begin
            out_valid <= rd_en;
            out_block <= rd_block;
            out_last  <= rd_en && (rd_block == block_t'(blocks - 1));
        end
    end

endmodule

`default_nettype wire

/* reorder_checker.sv */
`timescale 1ns/10ps
`default_nettype none

module reorder_checker import br_pkg::*; (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                clear,      // start of a new test
    input  logic [sample_w-1:0] base,
    input  logic [sample_w-1:0] step,
    input  logic                in_valid,
    input  logic                out_valid,
    input  sample_t             out_re [lanes],
    input  sample_t             out_im [lanes],
    input  block_t              out_block,
    input  logic                out_last,
    output int                  beat_count,
    output int                  error_count
);

    int   cycle;
    int   in_beats;       // beats into the frame on the input side
    int   exp_block;
    int   frame;          // output frame within the test
    logic valid_q;
    int   capture_q [$];  // edges that took the last beat of a frame

    // 9-bit index read back to front
    function automatic int reverse_index(input int idx);
        int r;
        r = 0;
        for (int k = 0; k < addr_bits; k++) begin
            r = (r << 1) | ((idx >> k) & 1);
        end
        return r;
    endfunction

    function automatic logic [sample_w-1:0] point_re(input int f, input int n);
        return sample_w'(int'(base) + 7 * f + int'(step) * n);
    endfunction

    task automatic check_rise();
        int latency;
        if (capture_q.size() == 0) begin
            $display("out_valid rose at cycle %0d with no finished input frame", cycle);
            error_count++;
        end else begin
            latency = (cycle - 1) - capture_q.pop_front();  // rise was the edge before
            if (latency != 2) begin
                $display("FAIL out_valid latency: expected 0x2, got 0x%0h", latency);
                error_count++;
            end
        end
    endtask

    task automatic check_beat();
        int                  n;
        logic [sample_w-1:0] exp_re;
        logic [sample_w-1:0] exp_im;
        if (out_block !== block_t'(exp_block)) begin
            $display("FAIL out_block frame %0d: expected 0x%0h, got 0x%0h",
                     frame, exp_block, out_block);
            error_count++;
        end
        if (out_last !== (exp_block == blocks - 1)) begin
            $display("FAIL out_last block %0d: expected 0x%0h, got 0x%0h",
                     exp_block, (exp_block == blocks - 1), out_last);
            error_count++;
        end
        for (int i = 0; i < lanes; i++) begin
            n      = reverse_index(exp_block * lanes + i);
            exp_re = point_re(frame, n);
            exp_im = ~exp_re;
            if (out_re[i] !== exp_re) begin
                $display("FAIL out_re[%0d] block %0d frame %0d: expected 0x%h, got 0x%h",
                         i, exp_block, frame, exp_re, out_re[i]);
                error_count++;
            end
            if (out_im[i] !== exp_im) begin
                $display("FAIL out_im[%0d] block %0d frame %0d: expected 0x%h, got 0x%h",
                         i, exp_block, frame, exp_im, out_im[i]);
                error_count++;
            end
        end
        beat_count++;
        if (exp_block == blocks - 1) begin
            exp_block = 0;
            frame++;
        end else begin
            exp_block++;
        end
    endtask

    always @(posedge clk) begin
        cycle++;
        if (!rst_n) begin
            if (out_valid === 1'b1 || out_last === 1'b1) begin
                $display("out_valid or out_last is high during reset");
                error_count++;
            end
            valid_q    = 1'b0;
            in_beats   = 0;
            exp_block  = 0;
            frame      = 0;
            beat_count = 0;
            capture_q.delete();
        end else if (clear) begin
            valid_q    = out_valid;
            in_beats   = 0;
            exp_block  = 0;
            frame      = 0;
            beat_count = 0;
            capture_q.delete();
        end else begin
            if (in_valid) begin
                if (in_beats == blocks - 1) begin
                    capture_q.push_back(cycle);
                    in_beats = 0;
                end else begin
                    in_beats++;
                end
            end
            if (out_valid && !valid_q) begin
                check_rise();
            end
            if (out_valid) begin
                check_beat();
            end else if (out_last) begin
                $display("out_last is high while out_valid is low");
                error_count++;
            end
            valid_q = out_valid;
        end
    end

endmodule

`default_nettype wire

/* reorder_props.sv */
`timescale 1ns/10ps
`default_nettype none

module reorder_props import br_pkg::*; (
    input logic       clk,
    input logic       rst_n,
    input logic       out_valid,
    input block_t     out_block,
    input logic       out_last,
    input logic       frame_ready,
    input seq_state_t seq_state
);

    int assert_fails;

    last_on_block_31: assert property (@(posedge clk) disable iff (!rst_n)
        out_last |-> out_valid && out_block == block_t'(blocks - 1))
        else begin
            assert_fails++;
            $error("out_last without a valid block 31");
        end

    // blocks of one frame come out back to back
    block_steps_by_one: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && $past(out_valid) |-> out_block == block_t'($past(out_block) + 1'b1))
        else begin
            assert_fails++;
            $error("out_block did not step by one");
        end

    ready_only_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
        frame_ready |-> seq_state == seq_idle)
        else begin
            assert_fails++;
            $error("frame_ready while the sequencer is still reading");
        end

endmodule

bind bitrev_reorder_top reorder_props i_reorder_props (
    .clk         (clk),
    .rst_n       (rst_n),
    .out_valid   (out_valid),
    .out_block   (out_block),
    .out_last    (out_last),
    .frame_ready (frame_ready),
    .seq_state   (i_read_sequencer.state)
);

`default_nettype wire

/* reorder_ram.sv */
`timescale 1ns/10ps
`default_nettype none

module reorder_ram import br_pkg::*; (
    input  logic    clk,
    input  logic    wr_en,
    input  bank_t   wr_bank,
    input  addr_t   wr_addr [lanes],
    input  sample_t wr_re [lanes],
    input  sample_t wr_im [lanes],
    input  logic    rd_en,
    input  bank_t   rd_bank,
    input  block_t  rd_block,
    output sample_t rd_re [lanes],
    output sample_t rd_im [lanes]
);

    // two frames of storage, one being filled while the other drains
    sample_t mem_re [2][frame_len];
    sample_t mem_im [2][frame_len];

    // 16 scattered writes per beat
    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int i = 0; i < lanes; i++) begin
                mem_re[wr_bank][wr_addr[i]] <= wr_re[i];
                mem_im[wr_bank][wr_addr[i]] <= wr_im[i];
            end
        end
    end

    // 16 consecutive words per read, registered
    // a same-edge write to the read bank is seen on the next read only
    always_ff @(posedge clk) begin
        if (rd_en) begin
            for (int i = 0; i < lanes; i++) begin
                rd_re[i] <= mem_re[rd_bank][{rd_block, lane_bits'(i)}];
                rd_im[i] <= mem_im[rd_bank][{rd_block, lane_bits'(i)}];
            end
        end
    end

endmodule

`default_nettype wire

/* reorder_vectors.txt */
# test  frames  base(hex)  step(hex)  gap  expected_beats
# gap 0 sends beats back to back, gap 1 puts 0 to 3 idle cycles before each beat
1  0  0000  0000  0  0
2  1  0000  0001  0  32
3  1  0123  0005  0  32
4  1  1ff0  1fff  0  32
5  4  00a0  0003  0  128
6  1  0040  0009  1  32
7  3  1000  0011  1  96
8  6  0abc  0007  0  192
9  2  0fff  0101  1  64
10 0  0000  0000  0  0

/* tb_bitrev_reorder.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_bitrev_reorder import br_pkg::*; ();

    localparam string vector_file = "reorder_vectors.txt";
    localparam int    max_gap     = 3;   // idle cycles between beats in gapped tests
    localparam int    pad_cycles  = 8;   // quiet time after the last expected beat

    logic    clk;
    logic    rst_n;
    logic    in_valid;
    sample_t in_re [lanes];
    sample_t in_im [lanes];
    logic    out_valid;
    sample_t out_re [lanes];
    sample_t out_im [lanes];
    block_t  out_block;
    logic    out_last;

    logic                clear;
    logic [sample_w-1:0] cur_base;
    logic [sample_w-1:0] cur_step;
    int                  beat_count;
    int                  check_errors;

    // one entry per line of the vector file
    int t_num [$];
    int t_frames [$];
    int t_base [$];
    int t_step [$];
    int t_gap [$];
    int t_beats [$];

    int cycles;
    int cycle_limit;
    int pass_count;
    int fail_count;
    int other_errors;

    bitrev_reorder_top i_bitrev_reorder_top (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_re     (in_re),
        .in_im     (in_im),
        .out_valid (out_valid),
        .out_re    (out_re),
        .out_im    (out_im),
        .out_block (out_block),
        .out_last  (out_last)
    );

    reorder_checker i_reorder_checker (
        .clk         (clk),
        .rst_n       (rst_n),
        .clear       (clear),
        .base        (cur_base),
        .step        (cur_step),
        .in_valid    (in_valid),
        .out_valid   (out_valid),
        .out_re      (out_re),
        .out_im      (out_im),
        .out_block   (out_block),
        .out_last    (out_last),
        .beat_count  (beat_count),
        .error_count (check_errors)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("timeout: run stopped after %0d cycles without finishing", cycles);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    task automatic read_vectors();
        int    fd;
        int    n;
        int    num;
        int    frames;
        int    base;
        int    step;
        int    gap;
        int    beats;
        string line;
        fd = $fopen(vector_file, "r");
        if (fd == 0) begin
            $display("cannot open %s", vector_file);
            other_errors++;
            return;
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() == 0 || line[0] == "#") begin
                continue;
            end
            n = $sscanf(line, "%d %d %h %h %d %d", num, frames, base, step, gap, beats);
            if (n == 6) begin
                t_num.push_back(num);
                t_frames.push_back(frames);
                t_base.push_back(base);
                t_step.push_back(step);
                t_gap.push_back(gap);
                t_beats.push_back(beats);
            end
        end
        $fclose(fd);
        if (t_num.size() == 0) begin
            $display("no tests found in %s", vector_file);
            other_errors++;
        end
    endtask

    // worst case per frame is 32 beats with 3 idle cycles before each plus latency
    function automatic int timeout_limit();
        int sum;
        sum = 0;
        foreach (t_frames[k]) begin
            sum += t_frames[k] * (blocks + max_gap * blocks + 4);
        end
        return 2 * sum + 200;
    endfunction

    function automatic int assert_failures();
        return i_bitrev_reorder_top.i_reorder_props.assert_fails;
    endfunction

    // lane i of beat b carries point b*16+i of frame f
    task automatic drive_frame(input int f, input int base, input int step, input int gapped);
        int                  gap;
        int                  n;
        logic [sample_w-1:0] re;
        for (int b = 0; b < blocks; b++) begin
            if (gapped != 0) begin
                gap = $urandom_range(max_gap);
                in_valid = 1'b0;
                repeat (gap) @(negedge clk);
            end
            in_valid = 1'b1;
            for (int i = 0; i < lanes; i++) begin
                n        = b * lanes + i;
                re       = sample_w'(base + 7 * f + step * n);
                in_re[i] = re;
                in_im[i] = ~re;
            end
            @(negedge clk);
        end
        in_valid = 1'b0;
    endtask

    task automatic run_test(input int k);
        int errs_before;
        int asserts_before;
        int local_errs;
        int test_errs;
        local_errs     = 0;
        errs_before    = check_errors;
        asserts_before = assert_failures();
        cur_base       = sample_w'(t_base[k]);
        cur_step       = sample_w'(t_step[k]);
        clear = 1'b1;
        @(negedge clk);
        clear = 1'b0;
        for (int f = 0; f < t_frames[k]; f++) begin
            drive_frame(f, t_base[k], t_step[k], t_gap[k]);
        end
        while (beat_count < t_beats[k]) begin
            @(negedge clk);
        end
        repeat (pad_cycles) @(negedge clk);  // catches stray beats
        if (beat_count != t_beats[k]) begin
            $display("FAIL out_valid beats: expected 0x%0h, got 0x%0h", t_beats[k], beat_count);
            local_errs++;
        end
        test_errs = (check_errors - errs_before) + local_errs
                  + (assert_failures() - asserts_before);
        if (test_errs == 0) begin
            $display("test %0d passed, %0d output beats", t_num[k], beat_count);
            pass_count++;
        end else begin
            $display("test %0d failed, %0d errors", t_num[k], test_errs);
            fail_count++;
        end
    endtask

    initial begin
        void'($urandom(12));
        rst_n    = 1'b0;
        in_valid = 1'b0;
        clear    = 1'b0;
        cur_base = '0;
        cur_step = '0;
        for (int i = 0; i < lanes; i++) begin
            in_re[i] = '0;
            in_im[i] = '0;
        end
        read_vectors();
        cycle_limit = timeout_limit();
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        other_errors += check_errors + assert_failures();  // seen in and just after reset
        for (int k = 0; k < t_num.size(); k++) begin
            run_test(k);
        end
        $display("tests passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0 && other_errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
